// ==== compile.f ====
design/uncore_msg_pkg.sv
design/uncore_map_pkg.sv
design/cmd_router.sv
design/resp_router.sv
design/cfg_regs.sv
design/clint_timer.sv
design/scratch_mem.sv
design/uncore_top.sv
tests/uncore_tb.sv

// ==== Bender.yml ====
package:
  name: uncore_tile

sources:
  - design/uncore_msg_pkg.sv
  - design/uncore_map_pkg.sv
  - design/cmd_router.sv
  - design/resp_router.sv
  - design/cfg_regs.sv
  - design/clint_timer.sv
  - design/scratch_mem.sv
  - design/uncore_top.sv
  - target: test
    files:
      - tests/uncore_tb.sv

// ==== tests/uncore_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module uncore_tb;

  localparam int NREQ        = uncore_msg_pkg::NUM_REQ;
  localparam int NROWS       = 18;
  localparam int WATCHDOG_NS = NROWS * 60 * 40;

  // Device number sits at bit 20 of a local address
  localparam uncore_msg_pkg::paddr_t DRAM_A  = 32'h8000_0040;
  localparam uncore_msg_pkg::paddr_t CACHE_A = 32'h0040_0020;
  localparam uncore_msg_pkg::paddr_t HOST_A  = 32'h0010_0018;
  localparam uncore_msg_pkg::paddr_t CFG_A   = 32'h0020_0000;
  localparam uncore_msg_pkg::paddr_t CLINT_A = 32'h0030_0000;

  logic clk_i;
  logic rst_i;
  logic [NREQ-1:0] req_cmd_v_i, req_cmd_we_i, req_cmd_yumi_o, resp_v_o, resp_yumi_i;
  uncore_msg_pkg::paddr_t [NREQ-1:0] req_cmd_addr_i;
  uncore_msg_pkg::dword_t [NREQ-1:0] req_cmd_data_i;
  uncore_msg_pkg::dword_t resp_data_o, io_cmd_data_o, io_resp_data_i;
  uncore_msg_pkg::paddr_t io_cmd_addr_o;
  uncore_msg_pkg::req_id_t io_cmd_id_o, io_resp_id_i;
  logic io_cmd_v_o, io_cmd_we_o, io_cmd_ready_i, io_resp_v_i, io_resp_yumi_o;
  logic timer_irq_o, software_irq_o, freeze_o;

  // Stimulus table; slot links a random write to its later read, sig picks an output
  string t_name [NROWS];
  int t_req [NROWS];
  int t_slot [NROWS];
  int t_sig [NROWS];
  bit t_we [NROWS];
  bit t_io [NROWS];
  bit t_sig_exp [NROWS];
  uncore_msg_pkg::paddr_t t_addr [NROWS];
  uncore_msg_pkg::dword_t t_data [NROWS];
  uncore_msg_pkg::dword_t t_exp [NROWS];
  uncore_msg_pkg::dword_t saved [4];
  logic [15:0] lfsr_state;
  int n_rows, err_cnt, test_cnt, fail_cnt;

  uncore_top #(.MEM_WORDS(64)) uut (.*);

  always #20 clk_i = ~clk_i;

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic next_word(output uncore_msg_pkg::dword_t w);
    w = '0;
    for (int b = 0; b < 64; b++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      w = {w[62:0], lfsr_state[0]};
    end
  endtask

  task automatic check_val(input string name, input uncore_msg_pkg::dword_t exp,
                           input uncore_msg_pkg::dword_t act);
    if (exp !== act)
    begin
      err_cnt++;
      $display("ERROR: %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic add_row(input string name, input int req, input bit we,
                         input uncore_msg_pkg::paddr_t addr, input uncore_msg_pkg::dword_t data,
                         input uncore_msg_pkg::dword_t exp, input bit io, input int slot,
                         input int sig, input bit sig_exp);
    t_name[n_rows] = name;
    t_req[n_rows] = req;
    t_we[n_rows] = we;
    t_addr[n_rows] = addr;
    t_data[n_rows] = data;
    t_exp[n_rows] = exp;
    t_io[n_rows] = io;
    t_slot[n_rows] = slot;
    t_sig[n_rows] = sig;
    t_sig_exp[n_rows] = sig_exp;
    n_rows++;
  endtask

  task automatic wait_yumi(input int r);
    @(negedge clk_i);
    while (req_cmd_yumi_o[r] !== 1'b1)
      @(negedge clk_i);
  endtask

  task automatic wait_resp(input int r, input string name, input uncore_msg_pkg::dword_t exp);
    @(negedge clk_i);
    while (resp_v_o[r] !== 1'b1)
      @(negedge clk_i);
    check_val(name, exp, resp_data_o);
  endtask

  // The I/O port is released only when its own response is the one popped
  task automatic pop_resp(input int r, input string name, input bit io);
    @(posedge clk_i);
    resp_yumi_i[r] <= 1'b1;
    @(negedge clk_i);
    check_val({name, "_io_yumi"}, io, io_resp_yumi_o);
    @(posedge clk_i);
    resp_yumi_i[r] <= 1'b0;
    io_resp_v_i    <= 1'b0;
  endtask

  task automatic report(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt != errs_before)
      fail_cnt++;
    $display("%-18s %s", name, (err_cnt == errs_before) ? "ok" : "mismatch");
  endtask

  task automatic run_row(input int i);
    uncore_msg_pkg::dword_t wdata;
    uncore_msg_pkg::dword_t exp;
    uncore_msg_pkg::dword_t io_word;
    int r;
    int errs_before;
    r = t_req[i];
    errs_before = err_cnt;
    wdata = t_data[i];
    exp = t_exp[i];
    if (t_slot[i] >= 0 && t_we[i])
    begin
      next_word(wdata);
      saved[t_slot[i]] = wdata;
    end
    else if (t_slot[i] >= 0)
      exp = saved[t_slot[i]];
    @(posedge clk_i);
    req_cmd_v_i[r]    <= 1'b1;
    req_cmd_we_i[r]   <= t_we[i];
    req_cmd_addr_i[r] <= t_addr[i];
    req_cmd_data_i[r] <= wdata;
    wait_yumi(r);
    check_val({t_name[i], "_io_v"}, t_io[i], io_cmd_v_o);
    if (t_io[i])
    begin
      check_val({t_name[i], "_io_addr"}, t_addr[i], io_cmd_addr_o);
      check_val({t_name[i], "_io_data"}, wdata, io_cmd_data_o);
      check_val({t_name[i], "_io_we"}, t_we[i], io_cmd_we_o);
      check_val({t_name[i], "_io_id"}, r, io_cmd_id_o);
    end
    @(posedge clk_i);
    req_cmd_v_i[r] <= 1'b0;
    if (t_io[i])
    begin
      // The I/O side answers with its own word, whatever the command was
      next_word(io_word);
      exp = io_word;
      io_resp_v_i    <= 1'b1;
      io_resp_data_i <= io_word;
      io_resp_id_i   <= uncore_msg_pkg::req_id_t'(r);
    end
    wait_resp(r, t_name[i], exp);
    case (t_sig[i])
      1: check_val({t_name[i], "_freeze"}, t_sig_exp[i], freeze_o);
      2: check_val({t_name[i], "_timer_irq"}, t_sig_exp[i], timer_irq_o);
      3: check_val({t_name[i], "_sw_irq"}, t_sig_exp[i], software_irq_o);
      default: ;
    endcase
    pop_resp(r, t_name[i], t_io[i]);
    report(t_name[i], errs_before);
  endtask

  // Both miss ports ask at once; the data side must win the first grant
  task automatic run_pair();
    int errs_before;
    errs_before = err_cnt;
    @(posedge clk_i);
    req_cmd_v_i[1:0]  <= 2'b11;
    req_cmd_we_i[1:0] <= 2'b00;
    req_cmd_addr_i[0] <= DRAM_A;
    req_cmd_addr_i[1] <= CACHE_A;
    @(negedge clk_i);
    check_val("pair_first_grant", 3'b010, req_cmd_yumi_o);
    @(posedge clk_i);
    req_cmd_v_i[1] <= 1'b0;
    wait_resp(1, "pair_req1_data", saved[1]);
    pop_resp(1, "pair_req1", 1'b0);
    wait_yumi(0);
    @(posedge clk_i);
    req_cmd_v_i[0] <= 1'b0;
    wait_resp(0, "pair_req0_data", saved[0]);
    pop_resp(0, "pair_req0", 1'b0);
    report("pair_arbitration", errs_before);
  endtask

  task automatic fill_table();
    add_row("mem_wr_dram", 0, 1, DRAM_A, 0, 0, 0, 0, 0, 0);
    add_row("mem_wr_cache", 1, 1, CACHE_A, 0, 0, 0, 1, 0, 0);
    add_row("mem_rd_dram", 0, 0, DRAM_A, 0, 0, 0, 0, 0, 0);
    add_row("mem_rd_cache", 1, 0, CACHE_A, 0, 0, 0, 1, 0, 0);
    add_row("cfg_rd_freeze", 0, 0, CFG_A, 0, 1, 0, -1, 1, 1);
    add_row("cfg_wr_freeze", 1, 1, CFG_A, 0, 0, 0, -1, 1, 0);
    add_row("cfg_rd_freeze0", 0, 0, CFG_A, 0, 0, 0, -1, 1, 0);
    add_row("cfg_wr_core_id", 0, 1, CFG_A + uncore_map_pkg::CFG_CORE_ID_OFS, 5, 0, 0, -1, 0, 0);
    add_row("cfg_rd_core_id", 1, 0, CFG_A + uncore_map_pkg::CFG_CORE_ID_OFS, 0, 5, 0, -1, 0, 0);
    add_row("cfg_wr_scratch", 0, 1, CFG_A + uncore_map_pkg::CFG_SCRATCH_OFS, 0, 0, 0, 2, 0, 0);
    add_row("cfg_rd_scratch", 1, 0, CFG_A + uncore_map_pkg::CFG_SCRATCH_OFS, 0, 0, 0, 2, 0, 0);
    add_row("clint_cmp_zero", 0, 1, CLINT_A + uncore_map_pkg::CLINT_MTIMECMP_OFS,
            0, 0, 0, -1, 2, 1);
    add_row("clint_cmp_ones", 0, 1, CLINT_A + uncore_map_pkg::CLINT_MTIMECMP_OFS,
            '1, 0, 0, -1, 2, 0);
    add_row("clint_msip_set", 1, 1, CLINT_A + uncore_map_pkg::CLINT_MSIP_OFS, 1, 0, 0, -1, 3, 1);
    add_row("clint_msip_clr", 1, 1, CLINT_A + uncore_map_pkg::CLINT_MSIP_OFS, 0, 0, 0, -1, 3, 0);
    add_row("io_host_wr", 1, 1, HOST_A, 0, 0, 1, 3, 0, 0);
    add_row("io_host_rd", 0, 0, HOST_A, 0, 0, 1, -1, 0, 0);
    add_row("io_in_rd_mem", 2, 0, DRAM_A, 0, 0, 0, 0, 0, 0);
  endtask

  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired: the run timed out before all tests finished");
    $display("Test failed");
    $finish;
  end

  initial
  begin
    int errs_before;
    clk_i = 1'b0;
    rst_i = 1'b1;
    req_cmd_v_i = '0;
    req_cmd_we_i = '0;
    req_cmd_addr_i = '0;
    req_cmd_data_i = '0;
    resp_yumi_i = '0;
    io_cmd_ready_i = 1'b1;
    io_resp_v_i = 1'b0;
    io_resp_data_i = '0;
    io_resp_id_i = '0;
    lfsr_state = 16'd58290;
    n_rows = 0;
    err_cnt = 0;
    test_cnt = 0;
    fail_cnt = 0;
    fill_table();
    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    errs_before = err_cnt;
    check_val("reset_low", 0, {req_cmd_yumi_o, resp_v_o, io_cmd_v_o, io_resp_yumi_o,
                               timer_irq_o, software_irq_o});
    check_val("reset_freeze", 1, freeze_o);
    report("reset_state", errs_before);
    for (int i = 0; i < NROWS; i++)
      run_row(i);
    run_pair();
    $display("Tests: %0d, failed: %0d, errors: %0d", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/uncore_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module uncore_top
  #(parameter int MEM_WORDS = 64)
  (input  logic                                                   clk_i
   , input  logic                                                 rst_i
   , input  logic [uncore_msg_pkg::NUM_REQ-1:0]                   req_cmd_v_i
   , input  logic [uncore_msg_pkg::NUM_REQ-1:0]                   req_cmd_we_i
   , input  uncore_msg_pkg::paddr_t [uncore_msg_pkg::NUM_REQ-1:0] req_cmd_addr_i
   , input  uncore_msg_pkg::dword_t [uncore_msg_pkg::NUM_REQ-1:0] req_cmd_data_i
   , output logic [uncore_msg_pkg::NUM_REQ-1:0]                   req_cmd_yumi_o
   , output logic [uncore_msg_pkg::NUM_REQ-1:0]                   resp_v_o
   , output uncore_msg_pkg::dword_t                               resp_data_o
   , input  logic [uncore_msg_pkg::NUM_REQ-1:0]                   resp_yumi_i
   // Outgoing I/O
   , output logic                                                 io_cmd_v_o
   , output logic                                                 io_cmd_we_o
   , output uncore_msg_pkg::paddr_t                               io_cmd_addr_o
   , output uncore_msg_pkg::dword_t                               io_cmd_data_o
   , output uncore_msg_pkg::req_id_t                              io_cmd_id_o
   , input  logic                                                 io_cmd_ready_i
   , input  logic                                                 io_resp_v_i
   , input  uncore_msg_pkg::dword_t                               io_resp_data_i
   , input  uncore_msg_pkg::req_id_t                              io_resp_id_i
   , output logic                                                 io_resp_yumi_o
   , output logic                                                 timer_irq_o
   , output logic                                                 software_irq_o
   , output logic                                                 freeze_o
   );

  logic cmd_we;
  uncore_msg_pkg::paddr_t cmd_addr;
  uncore_msg_pkg::dword_t cmd_data;
  uncore_msg_pkg::req_id_t cmd_id;

  logic cfg_v, cfg_ready, cfg_resp_v, cfg_resp_yumi;
  logic clint_v, clint_ready, clint_resp_v, clint_resp_yumi;
  logic mem_v, mem_ready, mem_resp_v, mem_resp_yumi;
  uncore_msg_pkg::dword_t cfg_resp_data, clint_resp_data, mem_resp_data;
  uncore_msg_pkg::req_id_t cfg_resp_id, clint_resp_id, mem_resp_id;

  // The I/O port sees the same selected command as the local devices
  assign io_cmd_we_o   = cmd_we;
  assign io_cmd_addr_o = cmd_addr;
  assign io_cmd_data_o = cmd_data;
  assign io_cmd_id_o   = cmd_id;

  cmd_router cmd_rtr
    (.clk_i, .rst_i
     ,.req_cmd_v_i, .req_cmd_we_i, .req_cmd_addr_i, .req_cmd_data_i, .req_cmd_yumi_o
     ,.cfg_ready_i(cfg_ready), .clint_ready_i(clint_ready)
     ,.mem_ready_i(mem_ready), .io_ready_i(io_cmd_ready_i)
     ,.cfg_v_o(cfg_v), .clint_v_o(clint_v), .mem_v_o(mem_v), .io_v_o(io_cmd_v_o)
     ,.cmd_we_o(cmd_we), .cmd_addr_o(cmd_addr), .cmd_data_o(cmd_data), .cmd_id_o(cmd_id)
     );

  cfg_regs cfg
    (.clk_i, .rst_i
     ,.cmd_v_i(cfg_v), .cmd_we_i(cmd_we), .cmd_addr_i(cmd_addr), .cmd_data_i(cmd_data)
     ,.cmd_id_i(cmd_id), .cmd_ready_o(cfg_ready)
     ,.resp_v_o(cfg_resp_v), .resp_data_o(cfg_resp_data), .resp_id_o(cfg_resp_id)
     ,.resp_yumi_i(cfg_resp_yumi), .freeze_o
     );

  clint_timer clint
    (.clk_i, .rst_i
     ,.cmd_v_i(clint_v), .cmd_we_i(cmd_we), .cmd_addr_i(cmd_addr), .cmd_data_i(cmd_data)
     ,.cmd_id_i(cmd_id), .cmd_ready_o(clint_ready)
     ,.resp_v_o(clint_resp_v), .resp_data_o(clint_resp_data), .resp_id_o(clint_resp_id)
     ,.resp_yumi_i(clint_resp_yumi), .timer_irq_o, .software_irq_o
     );

  scratch_mem #(.MEM_WORDS(MEM_WORDS)) mem
    (.clk_i, .rst_i
     ,.cmd_v_i(mem_v), .cmd_we_i(cmd_we), .cmd_addr_i(cmd_addr), .cmd_data_i(cmd_data)
     ,.cmd_id_i(cmd_id), .cmd_ready_o(mem_ready)
     ,.resp_v_o(mem_resp_v), .resp_data_o(mem_resp_data), .resp_id_o(mem_resp_id)
     ,.resp_yumi_i(mem_resp_yumi)
     );

  resp_router resp_rtr
    (.clk_i, .rst_i
     ,.cfg_resp_v_i(cfg_resp_v), .clint_resp_v_i(clint_resp_v)
     ,.mem_resp_v_i(mem_resp_v), .io_resp_v_i
     ,.cfg_resp_data_i(cfg_resp_data), .clint_resp_data_i(clint_resp_data)
     ,.mem_resp_data_i(mem_resp_data), .io_resp_data_i
     ,.cfg_resp_id_i(cfg_resp_id), .clint_resp_id_i(clint_resp_id)
     ,.mem_resp_id_i(mem_resp_id), .io_resp_id_i
     ,.cfg_resp_yumi_o(cfg_resp_yumi), .clint_resp_yumi_o(clint_resp_yumi)
     ,.mem_resp_yumi_o(mem_resp_yumi), .io_resp_yumi_o
     ,.resp_v_o, .resp_data_o, .resp_yumi_i
     );

endmodule

`default_nettype wire

// ==== design/scratch_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module scratch_mem
  #(parameter int MEM_WORDS = 64)
  (input  logic                      clk_i
   , input  logic                    rst_i
   , input  logic                    cmd_v_i
   , input  logic                    cmd_we_i
   , input  uncore_msg_pkg::paddr_t  cmd_addr_i
   , input  uncore_msg_pkg::dword_t  cmd_data_i
   , input  uncore_msg_pkg::req_id_t cmd_id_i
   , output logic                    cmd_ready_o
   , output logic                    resp_v_o
   , output uncore_msg_pkg::dword_t  resp_data_o
   , output uncore_msg_pkg::req_id_t resp_id_o
   , input  logic                    resp_yumi_i
   );

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  uncore_msg_pkg::dword_t mem_r [MEM_WORDS];
  logic [IDX_W-1:0] idx;

  // Word index wraps, so DRAM and cache-device aliases land in the same array
  assign idx = IDX_W'(cmd_addr_i[$bits(uncore_msg_pkg::paddr_t)-1:3] % MEM_WORDS);

  assign cmd_ready_o = ~resp_v_o;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      resp_v_o <= 1'b0;
    else if (cmd_v_i)
      resp_v_o <= 1'b1;
    else if (resp_yumi_i)
      resp_v_o <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_v_i)
    begin
      if (cmd_we_i)
        mem_r[idx] <= cmd_data_i;
      resp_data_o <= cmd_we_i ? '0 : mem_r[idx];
      resp_id_o   <= cmd_id_i;
    end
  end

  a_no_cmd_while_busy: assert property (@(posedge clk_i) disable iff (rst_i)
    cmd_v_i |-> cmd_ready_o);

endmodule

`default_nettype wire

// ==== design/clint_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module clint_timer
  (input  logic                      clk_i
   , input  logic                    rst_i
   , input  logic                    cmd_v_i
   , input  logic                    cmd_we_i
   , input  uncore_msg_pkg::paddr_t  cmd_addr_i
   , input  uncore_msg_pkg::dword_t  cmd_data_i
   , input  uncore_msg_pkg::req_id_t cmd_id_i
   , output logic                    cmd_ready_o
   , output logic                    resp_v_o
   , output uncore_msg_pkg::dword_t  resp_data_o
   , output uncore_msg_pkg::req_id_t resp_id_o
   , input  logic                    resp_yumi_i
   , output logic                    timer_irq_o
   , output logic                    software_irq_o
   );

  uncore_map_pkg::reg_ofs_t ofs;
  uncore_msg_pkg::dword_t mtime_r;
  uncore_msg_pkg::dword_t mtimecmp_r;
  uncore_msg_pkg::dword_t rd_data;
  logic msip_r;
  logic wr;

  assign ofs         = cmd_addr_i[$bits(uncore_map_pkg::reg_ofs_t)-1:0];
  assign wr          = cmd_v_i & cmd_we_i;
  assign cmd_ready_o = ~resp_v_o;

  assign timer_irq_o    = (mtime_r >= mtimecmp_r);
  assign software_irq_o = msip_r;

  always_comb
  begin
    case (ofs)
      uncore_map_pkg::CLINT_MSIP_OFS:     rd_data = {63'b0, msip_r};
      uncore_map_pkg::CLINT_MTIMECMP_OFS: rd_data = mtimecmp_r;
      uncore_map_pkg::CLINT_MTIME_OFS:    rd_data = mtime_r;
      default:                            rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      resp_v_o   <= 1'b0;
      msip_r     <= 1'b0;
      mtime_r    <= '0;
      // Compare parked at the top so the timer interrupt stays quiet
      mtimecmp_r <= '1;
    end
    else
    begin
      if (cmd_v_i)
        resp_v_o <= 1'b1;
      else if (resp_yumi_i)
        resp_v_o <= 1'b0;
      if (wr && ofs == uncore_map_pkg::CLINT_MSIP_OFS)
        msip_r <= cmd_data_i[0];
      if (wr && ofs == uncore_map_pkg::CLINT_MTIMECMP_OFS)
        mtimecmp_r <= cmd_data_i;
      if (wr && ofs == uncore_map_pkg::CLINT_MTIME_OFS)
        mtime_r <= cmd_data_i;
      else
        mtime_r <= mtime_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_v_i)
    begin
      resp_data_o <= cmd_we_i ? '0 : rd_data;
      resp_id_o   <= cmd_id_i;
    end
  end

endmodule

`default_nettype wire

// ==== design/cfg_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module cfg_regs
  (input  logic                      clk_i
   , input  logic                    rst_i
   , input  logic                    cmd_v_i
   , input  logic                    cmd_we_i
   , input  uncore_msg_pkg::paddr_t  cmd_addr_i
   , input  uncore_msg_pkg::dword_t  cmd_data_i
   , input  uncore_msg_pkg::req_id_t cmd_id_i
   , output logic                    cmd_ready_o
   , output logic                    resp_v_o
   , output uncore_msg_pkg::dword_t  resp_data_o
   , output uncore_msg_pkg::req_id_t resp_id_o
   , input  logic                    resp_yumi_i
   , output logic                    freeze_o
   );

  uncore_map_pkg::reg_ofs_t ofs;
  uncore_msg_pkg::dword_t core_id_r;
  uncore_msg_pkg::dword_t scratch_r;
  uncore_msg_pkg::dword_t rd_data;
  logic wr;

  assign ofs         = cmd_addr_i[$bits(uncore_map_pkg::reg_ofs_t)-1:0];
  assign wr          = cmd_v_i & cmd_we_i;
  assign cmd_ready_o = ~resp_v_o;

  always_comb
  begin
    case (ofs)
      uncore_map_pkg::CFG_FREEZE_OFS:  rd_data = {63'b0, freeze_o};
      uncore_map_pkg::CFG_CORE_ID_OFS: rd_data = core_id_r;
      uncore_map_pkg::CFG_SCRATCH_OFS: rd_data = scratch_r;
      default:                         rd_data = '0;
    endcase
  end

  // Core held frozen out of reset until the host clears it
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      resp_v_o  <= 1'b0;
      freeze_o  <= 1'b1;
      core_id_r <= '0;
    end
    else
    begin
      if (cmd_v_i)
        resp_v_o <= 1'b1;
      else if (resp_yumi_i)
        resp_v_o <= 1'b0;
      if (wr && ofs == uncore_map_pkg::CFG_FREEZE_OFS)
        freeze_o <= cmd_data_i[0];
      if (wr && ofs == uncore_map_pkg::CFG_CORE_ID_OFS)
        core_id_r <= cmd_data_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (wr && ofs == uncore_map_pkg::CFG_SCRATCH_OFS)
      scratch_r <= cmd_data_i;
    if (cmd_v_i)
    begin
      resp_data_o <= cmd_we_i ? '0 : rd_data;
      resp_id_o   <= cmd_id_i;
    end
  end

endmodule

`default_nettype wire

// ==== design/resp_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module resp_router
  (input  logic                                 clk_i
   , input  logic                               rst_i
   , input  logic                               cfg_resp_v_i
   , input  logic                               clint_resp_v_i
   , input  logic                               mem_resp_v_i
   , input  logic                               io_resp_v_i
   , input  uncore_msg_pkg::dword_t             cfg_resp_data_i
   , input  uncore_msg_pkg::dword_t             clint_resp_data_i
   , input  uncore_msg_pkg::dword_t             mem_resp_data_i
   , input  uncore_msg_pkg::dword_t             io_resp_data_i
   , input  uncore_msg_pkg::req_id_t            cfg_resp_id_i
   , input  uncore_msg_pkg::req_id_t            clint_resp_id_i
   , input  uncore_msg_pkg::req_id_t            mem_resp_id_i
   , input  uncore_msg_pkg::req_id_t            io_resp_id_i
   , output logic                               cfg_resp_yumi_o
   , output logic                               clint_resp_yumi_o
   , output logic                               mem_resp_yumi_o
   , output logic                               io_resp_yumi_o
   , output logic [uncore_msg_pkg::NUM_REQ-1:0] resp_v_o
   , output uncore_msg_pkg::dword_t             resp_data_o
   , input  logic [uncore_msg_pkg::NUM_REQ-1:0] resp_yumi_i
   );

  uncore_msg_pkg::req_id_t sel_id;
  logic any_v;
  logic pop;
  logic mem_gnt;
  logic io_gnt;
  logic clint_gnt;
  logic cfg_gnt;

  // Scratch memory first, then I/O, timer and config last
  assign mem_gnt   = mem_resp_v_i;
  assign io_gnt    = io_resp_v_i & ~mem_resp_v_i;
  assign clint_gnt = clint_resp_v_i & ~io_resp_v_i & ~mem_resp_v_i;
  assign cfg_gnt   = cfg_resp_v_i & ~clint_resp_v_i & ~io_resp_v_i & ~mem_resp_v_i;
  assign any_v     = mem_resp_v_i | io_resp_v_i | clint_resp_v_i | cfg_resp_v_i;

  always_comb
  begin
    if (mem_gnt)
    begin
      resp_data_o = mem_resp_data_i;
      sel_id      = mem_resp_id_i;
    end
    else if (io_gnt)
    begin
      resp_data_o = io_resp_data_i;
      sel_id      = io_resp_id_i;
    end
    else if (clint_gnt)
    begin
      resp_data_o = clint_resp_data_i;
      sel_id      = clint_resp_id_i;
    end
    else
    begin
      resp_data_o = cfg_resp_data_i;
      sel_id      = cfg_resp_id_i;
    end
  end

  for (genvar k = 0; k < uncore_msg_pkg::NUM_REQ; k++)
  begin : g_resp_v
    assign resp_v_o[k] = any_v & (sel_id == uncore_msg_pkg::req_id_t'(k));
  end

  // Only the addressed requester can see valid, so any pop belongs to the grant
  assign pop = |resp_yumi_i;

  assign mem_resp_yumi_o   = pop & mem_gnt;
  assign io_resp_yumi_o    = pop & io_gnt;
  assign clint_resp_yumi_o = pop & clint_gnt;
  assign cfg_resp_yumi_o   = pop & cfg_gnt;

  a_pop_needs_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    (resp_yumi_i & ~resp_v_o) == '0);

endmodule

`default_nettype wire

// ==== design/cmd_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmd_router
  (input  logic                                                   clk_i
   , input  logic                                                 rst_i
   , input  logic [uncore_msg_pkg::NUM_REQ-1:0]                   req_cmd_v_i
   , input  logic [uncore_msg_pkg::NUM_REQ-1:0]                   req_cmd_we_i
   , input  uncore_msg_pkg::paddr_t [uncore_msg_pkg::NUM_REQ-1:0] req_cmd_addr_i
   , input  uncore_msg_pkg::dword_t [uncore_msg_pkg::NUM_REQ-1:0] req_cmd_data_i
   , output logic [uncore_msg_pkg::NUM_REQ-1:0]                   req_cmd_yumi_o
   , input  logic                                                 cfg_ready_i
   , input  logic                                                 clint_ready_i
   , input  logic                                                 mem_ready_i
   , input  logic                                                 io_ready_i
   , output logic                                                 cfg_v_o
   , output logic                                                 clint_v_o
   , output logic                                                 mem_v_o
   , output logic                                                 io_v_o
   , output logic                                                 cmd_we_o
   , output uncore_msg_pkg::paddr_t                               cmd_addr_o
   , output uncore_msg_pkg::dword_t                               cmd_data_o
   , output uncore_msg_pkg::req_id_t                              cmd_id_o
   );

  uncore_msg_pkg::req_id_t sel;
  uncore_map_pkg::dev_id_t dev;
  logic all_ready;
  logic fire;
  logic is_local;
  logic is_mem;
  logic is_cfg;
  logic is_clint;

  // A busy I/O port holds off every requester, even ones bound for local devices
  assign all_ready = cfg_ready_i & clint_ready_i & mem_ready_i & io_ready_i;
  assign fire      = all_ready & (|req_cmd_v_i);

  // Highest index wins, so incoming I/O beats both miss ports
  always_comb
  begin
    sel = '0;
    for (int k = 0; k < uncore_msg_pkg::NUM_REQ; k++)
    begin
      if (req_cmd_v_i[k])
        sel = uncore_msg_pkg::req_id_t'(k);
    end
  end

  always_comb
  begin
    req_cmd_yumi_o = '0;
    if (fire)
      req_cmd_yumi_o[sel] = 1'b1;
  end

  assign cmd_we_o   = req_cmd_we_i[sel];
  assign cmd_addr_o = req_cmd_addr_i[sel];
  assign cmd_data_o = req_cmd_data_i[sel];
  assign cmd_id_o   = sel;

  assign is_local = cmd_addr_o < uncore_map_pkg::DRAM_BASE;
  assign dev      = cmd_addr_o[uncore_map_pkg::DEV_LSB +: $bits(uncore_map_pkg::dev_id_t)];
  assign is_mem   = ~is_local | (dev == uncore_map_pkg::CACHE_DEV);
  assign is_cfg   = is_local & (dev == uncore_map_pkg::CFG_DEV);
  assign is_clint = is_local & (dev == uncore_map_pkg::CLINT_DEV);

  assign cfg_v_o   = fire & is_cfg;
  assign clint_v_o = fire & is_clint;
  assign mem_v_o   = fire & is_mem;
  // Boot, host and any unmapped device number leave through the I/O port
  assign io_v_o    = fire & ~is_mem & ~is_cfg & ~is_clint;

  // A waiting requester keeps its command up until it is taken
  a_v_held_until_yumi: assert property (@(posedge clk_i) disable iff (rst_i)
    |(req_cmd_v_i & ~req_cmd_yumi_o) |=>
      ((~req_cmd_v_i & $past(req_cmd_v_i & ~req_cmd_yumi_o)) == '0));

endmodule

`default_nettype wire

// ==== design/uncore_map_pkg.sv ====
`default_nettype none

package uncore_map_pkg;

  typedef logic [3:0] dev_id_t;
  typedef logic [7:0] reg_ofs_t;

  // Below this address everything is a local device
  localparam uncore_msg_pkg::paddr_t DRAM_BASE = 32'h8000_0000;
  localparam int DEV_LSB = 20;

  localparam dev_id_t BOOT_DEV  = 4'd0;
  localparam dev_id_t HOST_DEV  = 4'd1;
  localparam dev_id_t CFG_DEV   = 4'd2;
  localparam dev_id_t CLINT_DEV = 4'd3;
  localparam dev_id_t CACHE_DEV = 4'd4;

  localparam reg_ofs_t CLINT_MSIP_OFS     = 8'h00;
  localparam reg_ofs_t CLINT_MTIMECMP_OFS = 8'h08;
  localparam reg_ofs_t CLINT_MTIME_OFS    = 8'h10;

  localparam reg_ofs_t CFG_FREEZE_OFS  = 8'h00;
  localparam reg_ofs_t CFG_CORE_ID_OFS = 8'h08;
  localparam reg_ofs_t CFG_SCRATCH_OFS = 8'h10;

endpackage

`default_nettype wire

// ==== design/uncore_msg_pkg.sv ====
`default_nettype none

package uncore_msg_pkg;

  // Every path in the uncore moves one 64-bit word per message
  localparam int PADDR_W  = 32;
  localparam int DWORD_W  = 64;
  localparam int REQ_ID_W = 2;

  // Fetch miss, data miss and incoming I/O
  localparam int NUM_REQ = 3;

  typedef logic [PADDR_W-1:0] paddr_t;

  typedef logic [DWORD_W-1:0] dword_t;

  typedef logic [REQ_ID_W-1:0] req_id_t;

endpackage

`default_nettype wire
